//--- bench/tb_decompress_tests.svh
////////////////////
// Compare tasks
////////////////////
task automatic check_coeff_word(input string what,
                                input decompress_pkg::coeff_word_t expected,
                                input decompress_pkg::coeff_word_t actual);
    if (expected !== actual) begin
        abort_run($sformatf("ERROR %s %s: expected %h, actual %h",
                            test_name, what, expected, actual));
    end
endtask

task automatic check_addr(input string what,
                          input logic [addr_w-1:0] expected,
                          input logic [addr_w-1:0] actual);
    if (expected !== actual) begin
        abort_run($sformatf("ERROR %s %s: expected %h, actual %h",
                            test_name, what, expected, actual));
    end
endtask

task automatic check_count(input string what, input int expected, input int actual);
    if (expected != actual) begin
        abort_run($sformatf("ERROR %s %s: expected %0d, actual %0d",
                            test_name, what, expected, actual));
    end
endtask

// Worst case with an idle cycle after every read
function automatic int job_cycles(input int bits, input int np);
    return 2 * 4 * bits * np + 64 * np + 100;
endfunction

function automatic int run_budget();
    return 16 + 100 + job_cycles(1, 1) + job_cycles(5, 2) + job_cycles(11, 2)
           + job_cycles(12, 2) + job_cycles(11, 2) + job_cycles(5, 1)
           + job_cycles(12, 3) + job_cycles(1, 2);
endfunction

////////////////////
// Reference model
////////////////////
// Stream bit k of a job sits in word src + k/64, LSB first
function automatic int stream_bit(input logic [addr_w-1:0] src, input int k);
    logic [addr_w-1:0] at;
    at = src + addr_w'(k / 64);
    return int'(src_mem[at][k % 64]);
endfunction

function automatic decompress_pkg::coeff_word_t expected_word(
    input logic [addr_w-1:0] src, input int bits, input int w);
    decompress_pkg::coeff_word_t result;
    int value;
    int coeff;
    result = '0;
    for (int lane = 0; lane < 4; lane++) begin
        value = 0;
        for (int b = 0; b < bits; b++) begin
            value = value | (stream_bit(src, (4 * w + lane) * bits + b) << b);
        end
        if (bits == 12) begin
            coeff = (value < 3329) ? value : 0;
        end else begin
            // Exact quotient, rounded half up from its remainder
            coeff = (3329 * value) / (1 << bits);
            if (2 * ((3329 * value) % (1 << bits)) >= (1 << bits)) begin
                coeff++;
            end
        end
        result[lane*24 +: 24] = 24'(coeff);
    end
    return result;
endfunction

task automatic start_job(input decompress_pkg::decompress_mode_t job_mode, input int np,
                         input logic [addr_w-1:0] src, input logic [addr_w-1:0] dst);
    rd_addr_q.delete();
    rd_cycle_q.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    wr_cycle_q.delete();
    done_cycle_q.delete();
    decompress_enable = 1'b1;
    mode              = job_mode;
    num_poly          = 3'(np);
    src_base_addr     = src;
    dest_base_addr    = dst;
    @(posedge pi_clk);
    #1;
    decompress_enable = 1'b0;
endtask

task automatic run_and_check(input string name, input decompress_pkg::decompress_mode_t m,
                             input int bits, input int np,
                             input logic [addr_w-1:0] src, input logic [addr_w-1:0] dst);
    int waited;
    test_name = name;
    waited    = 0;
    start_job(m, np, src, dst);
    while (done_cycle_q.size() == 0 && waited < job_cycles(bits, np)) begin
        @(posedge pi_clk);
        #1;
        waited++;
    end
    if (done_cycle_q.size() == 0) begin
        abort_run($sformatf("Test %s: decompress_done never arrived", name));
    end
    // One more cycle so a second done pulse would be seen
    @(posedge pi_clk);
    #1;
    check_count("read count", 4 * bits * np, rd_addr_q.size());
    check_count("enable to first read", 2, rd_cycle_q[0] - en_cycle);
    foreach (rd_addr_q[i]) begin
        check_addr($sformatf("read %0d address", i), src + addr_w'(i), rd_addr_q[i]);
    end
    check_count("write count", 64 * np, wr_addr_q.size());
    foreach (wr_addr_q[i]) begin
        check_addr($sformatf("write %0d address", i), dst + addr_w'(i), wr_addr_q[i]);
        check_coeff_word($sformatf("write %0d data", i), expected_word(src, bits, i),
                         wr_data_q[i]);
    end
    check_count("done pulses", 1, done_cycle_q.size());
    check_count("last write to done", 1, done_cycle_q[0] - wr_cycle_q[wr_cycle_q.size()-1]);
endtask

// Counts cycles with any of the three activity outputs high
task automatic count_active(input int cycles, output int active);
    active = 0;
    repeat (cycles) begin
        @(posedge pi_clk);
        #1;
        if (api_rd_en || mem_wr_en || decompress_done) begin
            active++;
        end
    end
endtask

////////////////////
// Directed tests
////////////////////
task automatic test_idle_after_reset();
    int active;
    test_name = "idle_after_reset";
    count_active(20, active);
    check_count("active output cycles", 0, active);
endtask

task automatic test_mode1_one_poly();
    run_and_check("mode1_one_poly", decompress_pkg::decompress1, 1, 1, 15'h0010, 15'h2000);
endtask

task automatic test_mode5_mode11_two_poly();
    run_and_check("mode5_two_poly", decompress_pkg::decompress5, 5, 2, 15'h0100, 15'h2400);
    run_and_check("mode11_two_poly", decompress_pkg::decompress11, 11, 2, 15'h0200, 15'h2800);
endtask

task automatic test_mode12_range();
    logic [addr_w-1:0] src;
    src = 15'h0400;
    // Lanes hold q, 4095, q - 1 and q + 1
    src_mem[src][47:0] = {12'd3330, 12'd3328, 12'd4095, 12'd3329};
    run_and_check("mode12_range", decompress_pkg::decompress12, 12, 2, src, 15'h4000);
    check_coeff_word("first write lanes", {24'd0, 24'd3328, 24'd0, 24'd0}, wr_data_q[0]);
endtask

task automatic test_zeroize_mid_job();
    int waited;
    int active;
    test_name = "zeroize_mid_job";
    waited    = 0;
    start_job(decompress_pkg::decompress11, 2, 15'h0800, 15'h5000);
    while (wr_addr_q.size() < 10 && waited < job_cycles(11, 2)) begin
        @(posedge pi_clk);
        #1;
        waited++;
    end
    check_count("writes before zeroize", 10, wr_addr_q.size());
    zeroize = 1'b1;
    @(posedge pi_clk);
    #1;
    zeroize = 1'b0;
    check_count("api_rd_en after zeroize", 0, int'(api_rd_en));
    check_count("mem_wr_en after zeroize", 0, int'(mem_wr_en));
    check_count("decompress_done after zeroize", 0, int'(decompress_done));
    count_active(20, active);
    check_count("active output cycles after zeroize", 0, active);
    check_count("done pulses of the dropped job", 0, done_cycle_q.size());
    run_and_check("zeroize_then_new_job", decompress_pkg::decompress5, 5, 1,
                  15'h0900, 15'h5800);
endtask

task automatic test_back_to_back();
    run_and_check("back_to_back_first", decompress_pkg::decompress12, 12, 3,
                  15'h1000, 15'h6000);
    run_and_check("back_to_back_second", decompress_pkg::decompress1, 1, 2,
                  15'h1200, 15'h7000);
endtask

//--- bench/tb_decompress.sv
`timescale 1ns/1ps

module tb_decompress;

    localparam int addr_w = 15;

    logic                             pi_clk;
    logic                             pi_reset_n;
    logic                             zeroize;
    logic                             decompress_enable;
    decompress_pkg::decompress_mode_t mode;
    logic [2:0]                       num_poly;
    logic [addr_w-1:0]                src_base_addr;
    logic [addr_w-1:0]                dest_base_addr;
    logic                             api_rd_en;
    logic [addr_w-1:0]                api_rd_addr;
    decompress_pkg::api_half_t [1:0]  api_rd_data;
    logic                             mem_wr_en;
    logic [addr_w-1:0]                mem_wr_addr;
    decompress_pkg::coeff_word_t      mem_wr_data;
    logic                             decompress_done;

    logic [decompress_pkg::api_word_w-1:0] src_mem [2**addr_w];

    // Activity seen at the rising edge, stamped with the cycle number
    int                          cycle = 0;
    int                          en_cycle;
    logic [addr_w-1:0]           rd_addr_q [$];
    int                          rd_cycle_q [$];
    logic [addr_w-1:0]           wr_addr_q [$];
    decompress_pkg::coeff_word_t wr_data_q [$];
    int                          wr_cycle_q [$];
    int                          done_cycle_q [$];
    string                       test_name;
    int                          fail_count = 0;
    int                          seed_ret;

    decompress_top #(.ADDR_W(addr_w)) i_dut (
        .pi_clk            (pi_clk),
        .pi_reset_n        (pi_reset_n),
        .zeroize           (zeroize),
        .decompress_enable (decompress_enable),
        .mode              (mode),
        .num_poly          (num_poly),
        .src_base_addr     (src_base_addr),
        .dest_base_addr    (dest_base_addr),
        .api_rd_en         (api_rd_en),
        .api_rd_addr       (api_rd_addr),
        .api_rd_data       (api_rd_data),
        .mem_wr_en         (mem_wr_en),
        .mem_wr_addr       (mem_wr_addr),
        .mem_wr_data       (mem_wr_data),
        .decompress_done   (decompress_done)
    );

    task automatic abort_run(input string reason);
        fail_count++;
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    `include "tb_decompress_tests.svh"

    always #4 pi_clk = ~pi_clk;

    // Source memory answers one cycle after each read
    always @(posedge pi_clk) begin : src_mem_model
        logic              rd_hit;
        logic [addr_w-1:0] rd_at;
        rd_hit = api_rd_en;
        rd_at  = api_rd_addr;
        #1;
        if (rd_hit) begin
            api_rd_data = src_mem[rd_at];
        end
    end

    ////////////////////
    // Bus monitor
    ////////////////////
    always @(posedge pi_clk) begin
        cycle = cycle + 1;
        if (pi_reset_n) begin
            if (decompress_enable) begin
                en_cycle = cycle;
            end
            if (api_rd_en) begin
                rd_addr_q.push_back(api_rd_addr);
                rd_cycle_q.push_back(cycle);
            end
            if (mem_wr_en) begin
                wr_addr_q.push_back(mem_wr_addr);
                wr_data_q.push_back(mem_wr_data);
                wr_cycle_q.push_back(cycle);
            end
            if (decompress_done) begin
                done_cycle_q.push_back(cycle);
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = run_budget();
        repeat (limit) @(posedge pi_clk);
        abort_run($sformatf("Timeout: the tests did not finish within %0d cycles", limit));
    end

    initial begin : main
        seed_ret          = $urandom(32'h17a8);
        pi_clk            = 1'b0;
        pi_reset_n        = 1'b0;
        zeroize           = 1'b0;
        decompress_enable = 1'b0;
        mode              = decompress_pkg::decompress1;
        num_poly          = '0;
        src_base_addr     = '0;
        dest_base_addr    = '0;
        api_rd_data       = '0;
        foreach (src_mem[a]) begin
            src_mem[a] = {$urandom(), $urandom()};
        end
        repeat (16) @(posedge pi_clk);
        #1;
        pi_reset_n = 1'b1;

        test_idle_after_reset();
        test_mode1_one_poly();
        test_mode5_mode11_two_poly();
        test_mode12_range();
        test_zeroize_mid_job();
        test_back_to_back();

        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Run ended with failures");
        end
    end

endmodule

//--- filelist.f
+incdir+bench
logic/decompress_pkg.sv
logic/decomp_job_if.sv
logic/decompress_ctrl.sv
logic/api_read_ctrl.sv
logic/piso_buffer.sv
logic/coeff_unpack_write.sv
logic/decompress_top.sv
bench/tb_decompress.sv

//--- logic/api_read_ctrl.sv
`timescale 1ns/1ps

module api_read_ctrl #(
    parameter int ADDR_W = 15
) (
    input  logic                                    pi_clk,
    input  logic                                    pi_reset_n,
    input  logic                                    zeroize,
    decomp_job_if.reader                            job,
    input  logic                                    room,
    output logic                                    api_rd_en,
    output logic [ADDR_W-1:0]                       api_rd_addr,
    input  decompress_pkg::api_half_t [1:0]         api_rd_data,
    output logic                                    word_valid,
    output logic [decompress_pkg::api_word_w-1:0]   word
);

    // Reads per job peak at 4 x 12 x 7
    localparam int cnt_w = $clog2(4 * 12 * 7 + 1);

    logic             active;
    logic             in_flight;
    logic [cnt_w-1:0] rd_cnt;
    logic [cnt_w-1:0] rd_cnt_next;
    logic [cnt_w-1:0] rd_target;

    // Four words per bit of compressed width, per polynomial
    assign rd_target = (cnt_w'(decompress_pkg::mode_bits(job.mode))
                        * cnt_w'(job.num_poly)) << 2;
    assign rd_cnt_next = rd_cnt + cnt_w'(1);

    // One read at a time, and only when a full word fits
    assign api_rd_en = active && room && !in_flight;

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            active      <= 1'b0;
            in_flight   <= 1'b0;
            rd_cnt      <= '0;
            api_rd_addr <= '0;
        end else if (zeroize) begin
            active      <= 1'b0;
            in_flight   <= 1'b0;
            rd_cnt      <= '0;
            api_rd_addr <= '0;
        end else begin
            in_flight <= api_rd_en;
            if (job.start) begin
                active      <= 1'b1;
                rd_cnt      <= '0;
                api_rd_addr <= job.src_base;
            end else if (api_rd_en) begin
                rd_cnt      <= rd_cnt_next;
                api_rd_addr <= api_rd_addr + ADDR_W'(1);
                if (rd_cnt_next == rd_target) begin
                    active <= 1'b0;
                end
            end
        end
    end

    ////////////////////
    // Read return path
    ////////////////////
    // Source memory answers one cycle after the read
    assign word_valid = in_flight;
    assign word       = {api_rd_data[1], api_rd_data[0]};

    // Reads never run past the length of the job
    a_read_in_job : assert property (
        @(posedge pi_clk) disable iff (!pi_reset_n || zeroize)
        api_rd_en |-> (rd_cnt < rd_target)
    );

endmodule

//--- logic/coeff_unpack_write.sv
`timescale 1ns/1ps

module coeff_unpack_write #(
    parameter int ADDR_W = 15
) (
    input  logic                                                    pi_clk,
    input  logic                                                    pi_reset_n,
    input  logic                                                    zeroize,
    decomp_job_if.writer                                            job,
    input  logic                                                    chunk_valid,
    input  logic [decompress_pkg::coeff_per_clk*decompress_pkg::q_w-1:0] chunk,
    output logic                                                    chunk_take,
    output logic                                                    mem_wr_en,
    output logic [ADDR_W-1:0]                                       mem_wr_addr,
    output decompress_pkg::coeff_word_t                             mem_wr_data,
    output logic                                                    last_write
);

    localparam int lanes  = decompress_pkg::coeff_per_clk;
    localparam int qw     = decompress_pkg::q_w;
    localparam int lane_w = decompress_pkg::coeff_w;
    localparam int prod_w = 2 * qw;
    localparam int cnt_w  = $clog2(decompress_pkg::writes_per_poly * 7 + 1);

    logic                        active;
    logic [ADDR_W-1:0]           wr_ptr;
    logic [cnt_w-1:0]            wr_cnt;
    logic [cnt_w-1:0]            wr_cnt_next;
    logic [cnt_w-1:0]            wr_target;
    logic                        final_take;
    logic [3:0]                  bits;
    logic [qw-1:0]               value [lanes];
    logic [prod_w-1:0]           prod [lanes];
    logic [qw-1:0]               coeff [lanes];
    decompress_pkg::coeff_word_t word_next;

    assign bits        = decompress_pkg::mode_bits(job.mode);
    assign chunk_take  = chunk_valid && active;
    assign wr_cnt_next = wr_cnt + cnt_w'(1);
    assign wr_target   = cnt_w'(decompress_pkg::writes_per_poly) * cnt_w'(job.num_poly);
    assign final_take  = chunk_take && (wr_cnt_next == wr_target);

    // Split the chunk into four values, lane 0 from the lowest bits
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            case (job.mode)
                decompress_pkg::decompress1:  value[i] = qw'(chunk[i]);
                decompress_pkg::decompress5:  value[i] = qw'(chunk[i*5 +: 5]);
                decompress_pkg::decompress11: value[i] = qw'(chunk[i*11 +: 11]);
                default:                      value[i] = chunk[i*12 +: 12];
            endcase
        end
    end

    ////////////////////
    // Decompression
    ////////////////////
    always_comb begin
        word_next = '0;
        for (int i = 0; i < lanes; i++) begin
            // round(q * v / 2^d) as (q * v + 2^(d-1)) >> d
            prod[i] = prod_w'(value[i]) * prod_w'(decompress_pkg::mlkem_q)
                      + (prod_w'(1) << (bits - 4'd1));
            if (job.mode == decompress_pkg::decompress12) begin
                // Out of range values become zero
                coeff[i] = (value[i] < qw'(decompress_pkg::mlkem_q)) ? value[i] : '0;
            end else begin
                coeff[i] = qw'(prod[i] >> bits);
            end
            word_next[i*lane_w +: lane_w] = decompress_pkg::coeff_t'(coeff[i]);
        end
    end

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            active     <= 1'b0;
            wr_cnt     <= '0;
            wr_ptr     <= '0;
            mem_wr_en  <= 1'b0;
            last_write <= 1'b0;
        end else if (zeroize) begin
            active     <= 1'b0;
            wr_cnt     <= '0;
            wr_ptr     <= '0;
            mem_wr_en  <= 1'b0;
            last_write <= 1'b0;
        end else begin
            mem_wr_en  <= chunk_take;
            last_write <= final_take;
            if (job.start) begin
                active <= 1'b1;
                wr_cnt <= '0;
                wr_ptr <= job.dest_base;
            end else if (chunk_take) begin
                wr_cnt <= wr_cnt_next;
                wr_ptr <= wr_ptr + ADDR_W'(1);
                if (final_take) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Write address and data
    always_ff @(posedge pi_clk) begin
        if (zeroize) begin
            mem_wr_addr <= '0;
            mem_wr_data <= '0;
        end else if (chunk_take) begin
            mem_wr_addr <= wr_ptr;
            mem_wr_data <= word_next;
        end
    end

endmodule

//--- logic/decomp_job_if.sv
`timescale 1ns/1ps

interface decomp_job_if #(
    parameter int ADDR_W = 15
);

    // Settings of the running job, stable from start until done
    logic                             start;
    decompress_pkg::decompress_mode_t mode;
    logic [2:0]                       num_poly;
    logic [ADDR_W-1:0]                src_base;
    logic [ADDR_W-1:0]                dest_base;

    modport controller (
        output start, mode, num_poly, src_base, dest_base
    );

    modport reader (
        input start, mode, num_poly, src_base
    );

    modport writer (
        input start, mode, num_poly, dest_base
    );

endinterface

//--- logic/decompress_ctrl.sv
`timescale 1ns/1ps

module decompress_ctrl #(
    parameter int ADDR_W = 15
) (
    input  logic                             pi_clk,
    input  logic                             pi_reset_n,
    input  logic                             zeroize,
    input  logic                             decompress_enable,
    input  decompress_pkg::decompress_mode_t mode,
    input  logic [2:0]                       num_poly,
    input  logic [ADDR_W-1:0]                src_base_addr,
    input  logic [ADDR_W-1:0]                dest_base_addr,
    input  logic                             last_write,
    decomp_job_if.controller                 job,
    output logic                             decompress_done
);

    logic busy;
    logic start_q;
    logic accept;

    // A new job is taken only from idle
    assign accept = decompress_enable && !busy;

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            busy            <= 1'b0;
            start_q         <= 1'b0;
            decompress_done <= 1'b0;
        end else if (zeroize) begin
            busy            <= 1'b0;
            start_q         <= 1'b0;
            decompress_done <= 1'b0;
        end else begin
            start_q         <= accept;
            decompress_done <= last_write;
            if (accept) begin
                busy <= 1'b1;
            end else if (last_write) begin
                busy <= 1'b0;
            end
        end
    end

    // Latched job settings
    always_ff @(posedge pi_clk) begin
        if (zeroize) begin
            job.mode      <= decompress_pkg::decompress1;
            job.num_poly  <= '0;
            job.src_base  <= '0;
            job.dest_base <= '0;
        end else if (accept) begin
            job.mode      <= mode;
            job.num_poly  <= num_poly;
            job.src_base  <= src_base_addr;
            job.dest_base <= dest_base_addr;
        end
    end

    assign job.start = start_q;

    // Host waits for done before it enables again
    a_no_enable_while_busy : assert property (
        @(posedge pi_clk) disable iff (!pi_reset_n || zeroize)
        busy |-> !decompress_enable
    );

endmodule

//--- logic/decompress_pkg.sv
package decompress_pkg;

    // ML-KEM ring parameters
    localparam int mlkem_n = 256;
    localparam int mlkem_q = 3329;
    localparam int q_w     = 12;

    // Memory side widths
    localparam int coeff_w       = 24;
    localparam int coeff_per_clk = 4;
    localparam int api_word_w    = 64;

    ////////////////////
    // Bit buffer sizing
    ////////////////////
    localparam int piso_w          = 104;
    // A whole read word still fits on top of this level
    localparam int piso_room_limit = piso_w - api_word_w;
    localparam int writes_per_poly = mlkem_n / coeff_per_clk;

    typedef enum logic [1:0] {
        decompress1  = 2'b00,
        decompress5  = 2'b01,
        decompress11 = 2'b10,
        decompress12 = 2'b11
    } decompress_mode_t;

    typedef logic [coeff_w-1:0]               coeff_t;
    typedef logic [coeff_per_clk*coeff_w-1:0] coeff_word_t;
    typedef logic [api_word_w/2-1:0]          api_half_t;

    // Compressed bits per coefficient
    function automatic logic [3:0] mode_bits(input decompress_mode_t mode);
        case (mode)
            decompress1:  mode_bits = 4'd1;
            decompress5:  mode_bits = 4'd5;
            decompress11: mode_bits = 4'd11;
            default:      mode_bits = 4'd12;
        endcase
    endfunction

endpackage

//--- logic/decompress_top.sv
`timescale 1ns/1ps

module decompress_top #(
    parameter int ADDR_W = 15
) (
    input  logic                             pi_clk,
    input  logic                             pi_reset_n,
    input  logic                             zeroize,
    input  logic                             decompress_enable,
    input  decompress_pkg::decompress_mode_t mode,
    input  logic [2:0]                       num_poly,
    input  logic [ADDR_W-1:0]                src_base_addr,
    input  logic [ADDR_W-1:0]                dest_base_addr,
    output logic                             api_rd_en,
    output logic [ADDR_W-1:0]                api_rd_addr,
    input  decompress_pkg::api_half_t [1:0]  api_rd_data,
    output logic                             mem_wr_en,
    output logic [ADDR_W-1:0]                mem_wr_addr,
    output decompress_pkg::coeff_word_t      mem_wr_data,
    output logic                             decompress_done
);

    localparam int chunk_w = decompress_pkg::coeff_per_clk * decompress_pkg::q_w;

    // Reader to buffer
    logic                                  room;
    logic                                  word_valid;
    logic [decompress_pkg::api_word_w-1:0] word;

    // Buffer to writer
    logic               chunk_valid;
    logic               chunk_take;
    logic [chunk_w-1:0] chunk;

    logic last_write;

    decomp_job_if #(.ADDR_W(ADDR_W)) i_job_if ();

    decompress_ctrl #(.ADDR_W(ADDR_W)) i_ctrl (
        .pi_clk            (pi_clk),
        .pi_reset_n        (pi_reset_n),
        .zeroize           (zeroize),
        .decompress_enable (decompress_enable),
        .mode              (mode),
        .num_poly          (num_poly),
        .src_base_addr     (src_base_addr),
        .dest_base_addr    (dest_base_addr),
        .last_write        (last_write),
        .job               (i_job_if.controller),
        .decompress_done   (decompress_done)
    );

    api_read_ctrl #(.ADDR_W(ADDR_W)) i_reader (
        .pi_clk      (pi_clk),
        .pi_reset_n  (pi_reset_n),
        .zeroize     (zeroize),
        .job         (i_job_if.reader),
        .room        (room),
        .api_rd_en   (api_rd_en),
        .api_rd_addr (api_rd_addr),
        .api_rd_data (api_rd_data),
        .word_valid  (word_valid),
        .word        (word)
    );

    piso_buffer i_piso (
        .pi_clk      (pi_clk),
        .pi_reset_n  (pi_reset_n),
        .zeroize     (zeroize),
        .mode        (i_job_if.mode),
        .word_valid  (word_valid),
        .word        (word),
        .room        (room),
        .chunk_valid (chunk_valid),
        .chunk       (chunk),
        .chunk_take  (chunk_take)
    );

    coeff_unpack_write #(.ADDR_W(ADDR_W)) i_writer (
        .pi_clk      (pi_clk),
        .pi_reset_n  (pi_reset_n),
        .zeroize     (zeroize),
        .job         (i_job_if.writer),
        .chunk_valid (chunk_valid),
        .chunk       (chunk),
        .chunk_take  (chunk_take),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .last_write  (last_write)
    );

endmodule

//--- logic/piso_buffer.sv
`timescale 1ns/1ps

module piso_buffer (
    input  logic                                                    pi_clk,
    input  logic                                                    pi_reset_n,
    input  logic                                                    zeroize,
    input  decompress_pkg::decompress_mode_t                        mode,
    input  logic                                                    word_valid,
    input  logic [decompress_pkg::api_word_w-1:0]                   word,
    output logic                                                    room,
    output logic                                                    chunk_valid,
    output logic [decompress_pkg::coeff_per_clk*decompress_pkg::q_w-1:0] chunk,
    input  logic                                                    chunk_take
);

    localparam int buf_w   = decompress_pkg::piso_w;
    localparam int word_w  = decompress_pkg::api_word_w;
    localparam int chunk_w = decompress_pkg::coeff_per_clk * decompress_pkg::q_w;
    localparam int fill_w  = $clog2(buf_w + 1);

    logic [buf_w-1:0]  data_q;
    logic [buf_w-1:0]  data_shift;
    logic [buf_w-1:0]  data_next;
    logic [fill_w-1:0] fill_q;
    logic [fill_w-1:0] fill_after;
    logic [fill_w-1:0] fill_next;
    logic [fill_w-1:0] chunk_bits;

    // Four values per chunk
    assign chunk_bits = fill_w'(decompress_pkg::mode_bits(mode)) << 2;

    assign chunk_valid = (fill_q >= chunk_bits);
    assign chunk       = data_q[chunk_w-1:0];
    assign room        = (fill_q <= fill_w'(decompress_pkg::piso_room_limit));

    ////////////////////
    // Next buffer state
    ////////////////////
    always_comb begin
        data_shift = data_q;
        fill_after = fill_q;
        // Consumed bits leave from the bottom first
        if (chunk_take) begin
            data_shift = data_q >> chunk_bits;
            fill_after = fill_q - chunk_bits;
        end
        data_next = data_shift;
        fill_next = fill_after;
        // New word goes right above the remaining bits
        if (word_valid) begin
            data_next = data_shift | (buf_w'(word) << fill_after);
            fill_next = fill_after + fill_w'(word_w);
        end
    end

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            data_q <= '0;
            fill_q <= '0;
        end else if (zeroize) begin
            data_q <= '0;
            fill_q <= '0;
        end else begin
            data_q <= data_next;
            fill_q <= fill_next;
        end
    end

    // Holds only while the reader respects room
    a_fill_in_range : assert property (
        @(posedge pi_clk) disable iff (!pi_reset_n || zeroize)
        fill_q <= fill_w'(buf_w)
    );

endmodule
